/* src/mcu_periph_pkg.sv */
// Shared widths, address region bases and register offsets for the MCU peripheral block
`default_nettype none

package mcu_periph_pkg;

	// Bus and register widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int OFFS_W = 8;   // Byte offset inside one 256-byte region

	// Upper address bits that select a region
	localparam logic [ADDR_W-OFFS_W-1:0] CPU_REG_BASE   = '1;          // CPU side, FFFFFFxx
	localparam logic [ADDR_W-OFFS_W-1:0] HOST_MBOX_BASE = 24'hF00000;  // Host side, F00000xx

	// Mailbox
	localparam int MBOX_COUNT = 8;                   // Offsets 00 to 1C, one word each
	localparam int MBOX_IDX_W = $clog2(MBOX_COUNT);

	// Dataslot field widths
	localparam int SLOT_ID_W  = 16;
	localparam int SLOT_ERR_W = 3;

	// Dataslot register offsets
	localparam logic [OFFS_W-1:0] OFFS_SLOT_ID     = 8'h80;
	localparam logic [OFFS_W-1:0] OFFS_SLOT_ADDR   = 8'h84;  // Bridge address
	localparam logic [OFFS_W-1:0] OFFS_SLOT_LEN    = 8'h88;
	localparam logic [OFFS_W-1:0] OFFS_SLOT_OFFSET = 8'h8C;
	// Control on write, status on read
	localparam logic [OFFS_W-1:0] OFFS_SLOT_CTRL   = 8'h90;

	// Timer register offsets
	localparam logic [OFFS_W-1:0] OFFS_TICK_PERIOD = 8'h98;  // Clocks per millisecond minus one
	localparam logic [OFFS_W-1:0] OFFS_MS_COUNT    = 8'hC4;
	localparam logic [OFFS_W-1:0] OFFS_IRQ_THRESH  = 8'hC8;
	localparam logic [OFFS_W-1:0] OFFS_IRQ_MASK    = 8'hF4;

endpackage

`default_nettype wire

/* src/cpu_bus_decoder.sv */
// CPU command decode into block select strobes, one-cycle response and read data mux
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_decoder import mcu_periph_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              cmd_valid,
	input  logic [ADDR_W-1:0] cmd_addr,
	input  logic [DATA_W-1:0] mbox_rd_data,
	input  logic [DATA_W-1:0] timer_rd_data,
	input  logic [DATA_W-1:0] slot_rd_data,
	output logic              mbox_sel,
	output logic              timer_sel,
	output logic              slot_sel,
	output logic [OFFS_W-1:0] reg_offset,
	output logic              rsp_ready,
	output logic [DATA_W-1:0] rsp_data
);

	logic in_region;   // Upper address bits match the register region
	logic hit_mbox;
	logic hit_timer;
	logic hit_slot;
	// Block that owns the response in the next cycle
	logic mbox_q;
	logic timer_q;
	logic slot_q;

	assign reg_offset = cmd_addr[OFFS_W-1:0];
	assign in_region  = cmd_addr[ADDR_W-1:OFFS_W] == CPU_REG_BASE;

	// Classify the offset, anything else stays unmapped
	always_comb begin
		hit_mbox  = 1'b0;
		hit_timer = 1'b0;
		hit_slot  = 1'b0;
		// Mailbox is the word-aligned block at the bottom of the region
		if (reg_offset[1:0] == 2'b00 && reg_offset < OFFS_W'(MBOX_COUNT * 4)) begin
			hit_mbox = 1'b1;
		end
		case (reg_offset)
			OFFS_SLOT_ID, OFFS_SLOT_ADDR, OFFS_SLOT_LEN,
			OFFS_SLOT_OFFSET, OFFS_SLOT_CTRL: begin
				hit_slot = 1'b1;
			end
			OFFS_TICK_PERIOD, OFFS_MS_COUNT,
			OFFS_IRQ_THRESH, OFFS_IRQ_MASK: begin
				hit_timer = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// Strobes last only for the command cycle
	assign mbox_sel  = cmd_valid && in_region && hit_mbox;
	assign timer_sel = cmd_valid && in_region && hit_timer;
	assign slot_sel  = cmd_valid && in_region && hit_slot;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rsp_ready <= 1'b0;
			mbox_q    <= 1'b0;
			timer_q   <= 1'b0;
			slot_q    <= 1'b0;
		end else begin
			rsp_ready <= cmd_valid;   // Every command answers, mapped or not
			mbox_q    <= mbox_sel;
			timer_q   <= timer_sel;
			slot_q    <= slot_sel;
		end
	end

	// One-hot AND-OR mux, no owner gives zero
	assign rsp_data = ({DATA_W{mbox_q}}  & mbox_rd_data)
	                | ({DATA_W{timer_q}} & timer_rd_data)
	                | ({DATA_W{slot_q}}  & slot_rd_data);

endmodule

`default_nettype wire

/* src/mailbox_regs.sv */
// Eight mailbox registers shared by the CPU bus and the host bridge
`timescale 1ns/100ps
`default_nettype none

module mailbox_regs import mcu_periph_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              mbox_sel,
	input  logic              cmd_wr,
	input  logic [OFFS_W-1:0] reg_offset,
	input  logic [DATA_W-1:0] cmd_wr_data,
	input  logic              bridge_wr,
	input  logic              bridge_rd,
	input  logic [ADDR_W-1:0] bridge_addr,
	input  logic [DATA_W-1:0] bridge_wr_data,
	output logic [DATA_W-1:0] mbox_rd_data,
	output logic [DATA_W-1:0] bridge_rd_data
);

	logic [DATA_W-1:0]     mbox [MBOX_COUNT];
	logic [DATA_W-1:0]     host_rd_q;    // First host read stage
	logic                  host_hit;     // Host address inside the mailbox window
	logic [MBOX_IDX_W-1:0] host_idx;
	logic [MBOX_IDX_W-1:0] cpu_idx;

	assign host_hit = bridge_addr[ADDR_W-1:OFFS_W] == HOST_MBOX_BASE
	               && bridge_addr[OFFS_W-1:0] < OFFS_W'(MBOX_COUNT * 4);
	assign host_idx = bridge_addr[2 +: MBOX_IDX_W];   // Word index
	assign cpu_idx  = reg_offset[2 +: MBOX_IDX_W];

	// Per-register priority, host write beats a CPU write to the same word
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < MBOX_COUNT; i++) begin
				mbox[i] <= '0;
			end
		end else begin
			for (int i = 0; i < MBOX_COUNT; i++) begin
				if (bridge_wr && host_hit && host_idx == MBOX_IDX_W'(i)) begin
					mbox[i] <= bridge_wr_data;
				end else if (mbox_sel && cmd_wr && cpu_idx == MBOX_IDX_W'(i)) begin
					mbox[i] <= cmd_wr_data;
				end
			end
		end
	end

	// CPU read, one stage. Host read, two stages held until the next read
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			mbox_rd_data   <= '0;
			host_rd_q      <= '0;
			bridge_rd_data <= '0;
		end else begin
			if (mbox_sel && !cmd_wr) begin
				mbox_rd_data <= mbox[cpu_idx];
			end
			if (bridge_rd && host_hit) begin
				host_rd_q <= mbox[host_idx];
			end
			bridge_rd_data <= host_rd_q;   // Holds while the first stage holds
		end
	end

endmodule

`default_nettype wire

/* src/ms_timer.sv */
// Millisecond counter with programmable tick period, threshold interrupt and mask
`timescale 1ns/100ps
`default_nettype none

module ms_timer import mcu_periph_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              timer_sel,
	input  logic              cmd_wr,
	input  logic [OFFS_W-1:0] reg_offset,
	input  logic [DATA_W-1:0] cmd_wr_data,
	output logic [DATA_W-1:0] timer_rd_data,
	output logic              timer_irq
);

	logic [DATA_W-1:0] tick_period;
	logic [DATA_W-1:0] tick_cnt;
	logic [DATA_W-1:0] ms_count;
	logic [DATA_W-1:0] irq_thresh;
	logic              irq_mask;
	logic              irq_armed;   // Set by a threshold write, cleared by a count write
	logic              irq_flag;    // Count has reached the threshold
	logic              ms_step;
	logic              count_clr;

	assign ms_step   = tick_cnt == tick_period;   // Period plus one clocks per step
	assign count_clr = timer_sel && cmd_wr && reg_offset == OFFS_MS_COUNT && cmd_wr_data[0];

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt <= '0;
			ms_count <= '0;
			irq_flag <= 1'b0;
		end else if (count_clr) begin
			tick_cnt <= '0;
			ms_count <= '0;
			irq_flag <= 1'b0;
		end else if (ms_step) begin
			tick_cnt <= '0;
			ms_count <= ms_count + 1'b1;
			if (irq_thresh != '0 && ms_count >= irq_thresh) begin
				irq_flag <= 1'b1;   // Zero threshold never fires
			end
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Register writes and registered read data
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			tick_period   <= '0;
			irq_thresh    <= '0;
			irq_mask      <= 1'b0;
			irq_armed     <= 1'b0;
			timer_rd_data <= '0;
		end else if (timer_sel && cmd_wr) begin
			case (reg_offset)
				OFFS_TICK_PERIOD: tick_period <= cmd_wr_data;
				OFFS_MS_COUNT:    irq_armed   <= 1'b0;
				OFFS_IRQ_THRESH: begin
					irq_thresh <= cmd_wr_data;
					irq_armed  <= 1'b1;
				end
				OFFS_IRQ_MASK:    irq_mask    <= cmd_wr_data[0];
				default: begin
				end
			endcase
		end else if (timer_sel) begin
			case (reg_offset)
				OFFS_TICK_PERIOD: timer_rd_data <= tick_period;
				OFFS_MS_COUNT:    timer_rd_data <= ms_count;
				OFFS_IRQ_THRESH:  timer_rd_data <= irq_thresh;
				OFFS_IRQ_MASK:    timer_rd_data <= {{(DATA_W-1){1'b0}}, irq_mask};
				default:          timer_rd_data <= '0;
			endcase
		end
	end

	assign timer_irq = irq_flag && irq_armed && irq_mask;

endmodule

`default_nettype wire

/* src/dataslot_cmd.sv */
// Dataslot parameter registers, read and write command pulses, status readback and done interrupt
`timescale 1ns/100ps
`default_nettype none

module dataslot_cmd import mcu_periph_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  slot_sel,
	input  logic                  cmd_wr,
	input  logic [OFFS_W-1:0]     reg_offset,
	input  logic [DATA_W-1:0]     cmd_wr_data,
	input  logic                  target_dataslot_ack,
	input  logic                  target_dataslot_done,
	input  logic [SLOT_ERR_W-1:0] target_dataslot_err,
	output logic [DATA_W-1:0]     slot_rd_data,
	output logic                  target_dataslot_read,
	output logic                  target_dataslot_write,
	output logic [SLOT_ID_W-1:0]  target_dataslot_id,
	output logic [DATA_W-1:0]     target_dataslot_bridgeaddr,
	output logic [DATA_W-1:0]     target_dataslot_length,
	output logic [DATA_W-1:0]     target_dataslot_slotoffset,
	output logic                  slot_irq
);

	logic done_q;    // Previous done, for edge detect
	logic irq_en;
	logic ctrl_wr;
	logic ctrl_rd;

	assign ctrl_wr = slot_sel && cmd_wr && reg_offset == OFFS_SLOT_CTRL;
	assign ctrl_rd = slot_sel && !cmd_wr && reg_offset == OFFS_SLOT_CTRL;

	// Parameters and read data
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
			slot_rd_data               <= '0;
		end else if (slot_sel && cmd_wr) begin
			case (reg_offset)
				OFFS_SLOT_ID:     target_dataslot_id         <= cmd_wr_data[SLOT_ID_W-1:0];
				OFFS_SLOT_ADDR:   target_dataslot_bridgeaddr <= cmd_wr_data;
				OFFS_SLOT_LEN:    target_dataslot_length     <= cmd_wr_data;
				OFFS_SLOT_OFFSET: target_dataslot_slotoffset <= cmd_wr_data;
				default: begin
				end
			endcase
		end else if (slot_sel) begin
			case (reg_offset)
				OFFS_SLOT_ID:     slot_rd_data <= {{(DATA_W-SLOT_ID_W){1'b0}}, target_dataslot_id};
				OFFS_SLOT_ADDR:   slot_rd_data <= target_dataslot_bridgeaddr;
				OFFS_SLOT_LEN:    slot_rd_data <= target_dataslot_length;
				OFFS_SLOT_OFFSET: slot_rd_data <= target_dataslot_slotoffset;
				// Status word {ack, done, err}
				OFFS_SLOT_CTRL:   slot_rd_data <= {{(DATA_W-SLOT_ERR_W-2){1'b0}},
				                                   target_dataslot_ack, target_dataslot_done,
				                                   target_dataslot_err};
				default:          slot_rd_data <= '0;
			endcase
		end
	end

	// Command pulses, enable and done interrupt
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_read  <= 1'b0;
			target_dataslot_write <= 1'b0;
			irq_en                <= 1'b0;
			done_q                <= 1'b0;
			slot_irq              <= 1'b0;
		end else begin
			target_dataslot_read  <= ctrl_wr && cmd_wr_data[0];
			// Read wins if both bits are set, one command at a time
			target_dataslot_write <= ctrl_wr && cmd_wr_data[1] && !cmd_wr_data[0];
			if (ctrl_wr) begin
				irq_en <= cmd_wr_data[2];
			end
			done_q <= target_dataslot_done;
			if (ctrl_rd) begin
				slot_irq <= 1'b0;   // Status read acknowledges
			end else if (target_dataslot_done && !done_q && irq_en) begin
				slot_irq <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/mcu_periph_top.sv */
// Peripheral block top: CPU bus decoder, mailbox, millisecond timer and dataslot command unit
`timescale 1ns/100ps
`default_nettype none

module mcu_periph_top import mcu_periph_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	// CPU data bus
	input  logic                  cmd_valid,
	input  logic                  cmd_wr,
	input  logic [ADDR_W-1:0]     cmd_addr,
	input  logic [DATA_W-1:0]     cmd_wr_data,
	output logic                  rsp_ready,
	output logic [DATA_W-1:0]     rsp_data,
	// Host bridge, mailbox window only
	input  logic                  bridge_wr,
	input  logic                  bridge_rd,
	input  logic [ADDR_W-1:0]     bridge_addr,
	input  logic [DATA_W-1:0]     bridge_wr_data,
	output logic [DATA_W-1:0]     bridge_rd_data,
	// Dataslot target interface
	output logic                  target_dataslot_read,
	output logic                  target_dataslot_write,
	input  logic                  target_dataslot_ack,
	input  logic                  target_dataslot_done,
	input  logic [SLOT_ERR_W-1:0] target_dataslot_err,
	output logic [SLOT_ID_W-1:0]  target_dataslot_id,
	output logic [DATA_W-1:0]     target_dataslot_bridgeaddr,
	output logic [DATA_W-1:0]     target_dataslot_length,
	output logic [DATA_W-1:0]     target_dataslot_slotoffset,
	// Interrupt levels
	output logic                  timer_irq,
	output logic                  slot_irq
);

	logic              mbox_sel;
	logic              timer_sel;
	logic              slot_sel;
	logic [OFFS_W-1:0] reg_offset;     // Shared by all blocks
	logic [DATA_W-1:0] mbox_rd_data;
	logic [DATA_W-1:0] timer_rd_data;
	logic [DATA_W-1:0] slot_rd_data;

	cpu_bus_decoder i_decoder (
		.clk_sys, .reset_n,
		.cmd_valid, .cmd_addr,
		.mbox_rd_data, .timer_rd_data, .slot_rd_data,
		.mbox_sel, .timer_sel, .slot_sel,
		.reg_offset,
		.rsp_ready, .rsp_data
	);

	mailbox_regs i_mailbox (
		.clk_sys, .reset_n,
		.mbox_sel, .cmd_wr, .reg_offset, .cmd_wr_data,
		.bridge_wr, .bridge_rd, .bridge_addr, .bridge_wr_data,
		.mbox_rd_data, .bridge_rd_data
	);

	ms_timer i_timer (
		.clk_sys, .reset_n,
		.timer_sel, .cmd_wr, .reg_offset, .cmd_wr_data,
		.timer_rd_data, .timer_irq
	);

	dataslot_cmd i_dataslot (
		.clk_sys, .reset_n,
		.slot_sel, .cmd_wr, .reg_offset, .cmd_wr_data,
		.target_dataslot_ack, .target_dataslot_done, .target_dataslot_err,
		.slot_rd_data,
		.target_dataslot_read, .target_dataslot_write,
		.target_dataslot_id, .target_dataslot_bridgeaddr,
		.target_dataslot_length, .target_dataslot_slotoffset,
		.slot_irq
	);

endmodule

`default_nettype wire

/* sim/mcu_periph_properties.sv */
// Bound assertions on CPU response timing, dataslot command pulses and interrupt reset state
`timescale 1ns/100ps
`default_nettype none

module mcu_periph_properties import mcu_periph_pkg::*; (
	input logic clk_sys,
	input logic reset_n,
	input logic cmd_valid,
	input logic rsp_ready,
	input logic target_dataslot_read,
	input logic target_dataslot_write,
	input logic timer_irq,
	input logic slot_irq
);

	// Every command answers in the next cycle
	rsp_follows_cmd: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cmd_valid |=> rsp_ready)
		else $error("rsp_ready missing one cycle after cmd_valid");

	// No response without a command one cycle before
	no_stray_rsp: assert property (@(posedge clk_sys) disable iff (!reset_n)
		rsp_ready |-> $past(cmd_valid))
		else $error("rsp_ready without a preceding cmd_valid");

	pulses_exclusive: assert property (@(posedge clk_sys)
		!(target_dataslot_read && target_dataslot_write))
		else $error("dataslot read and write pulses high together");

	irq_low_in_reset: assert property (@(posedge clk_sys)
		!reset_n |-> !timer_irq && !slot_irq)
		else $error("interrupt high while reset is asserted");

endmodule

bind mcu_periph_top mcu_periph_properties i_props (
	.clk_sys(clk_sys),
	.reset_n(reset_n),
	.cmd_valid(cmd_valid),
	.rsp_ready(rsp_ready),
	.target_dataslot_read(target_dataslot_read),
	.target_dataslot_write(target_dataslot_write),
	.timer_irq(timer_irq),
	.slot_irq(slot_irq)
);

`default_nettype wire

/* sim/tb_mcu_periph.sv */
// Testbench with clock, reset, CPU and host bus tasks, register model, response compare and summary
`timescale 1ns/100ps
`default_nettype none

module tb_mcu_periph import mcu_periph_pkg::*; ();

	localparam int TIMEOUT = 200;   // Cycles allowed for any wait
	localparam logic [ADDR_W-1:0] CPU_BASE  = {CPU_REG_BASE, 8'h00};
	localparam logic [ADDR_W-1:0] HOST_BASE = {HOST_MBOX_BASE, 8'h00};

	logic clk_sys, reset_n, cmd_valid, cmd_wr, rsp_ready;
	logic [ADDR_W-1:0] cmd_addr, bridge_addr;
	logic [DATA_W-1:0] cmd_wr_data, rsp_data, bridge_wr_data, bridge_rd_data;
	logic bridge_wr, bridge_rd, timer_irq, slot_irq;
	logic target_dataslot_read, target_dataslot_write, target_dataslot_ack, target_dataslot_done;
	logic [SLOT_ERR_W-1:0] target_dataslot_err;
	logic [SLOT_ID_W-1:0] target_dataslot_id;
	logic [DATA_W-1:0] target_dataslot_bridgeaddr, target_dataslot_length;
	logic [DATA_W-1:0] target_dataslot_slotoffset;

	// Register model
	logic [DATA_W-1:0] mbox_model [MBOX_COUNT];
	logic [DATA_W-1:0] slot_id_m, slot_addr_m, slot_len_m, slot_offs_m, tick_m, thresh_m;
	logic mask_m;
	logic [DATA_W-1:0] host_last;   // Word the host bridge shows until the next read
	// Outstanding commands in issue order
	logic [DATA_W-1:0] pend_exp [$];
	bit pend_chk [$];
	string pend_name [$];
	logic [DATA_W-1:0] last_rd;
	int seed = 46;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err0 = 0;
	int read_pulses = 0;
	int write_pulses = 0;
	string test_name;

	mcu_periph_top i_dut (.*);

	always #20 clk_sys = ~clk_sys;

	function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
		logic [OFFS_W-1:0] offs;
		offs = addr[OFFS_W-1:0];
		if (addr[ADDR_W-1:OFFS_W] != CPU_REG_BASE) return '0;   // Outside the region
		if (offs < 8'h20 && offs[1:0] == 2'b00) return mbox_model[offs[4:2]];
		case (offs)
			OFFS_SLOT_ID:     return {16'h0, slot_id_m[15:0]};   // Id keeps 16 bits
			OFFS_SLOT_ADDR:   return slot_addr_m;
			OFFS_SLOT_LEN:    return slot_len_m;
			OFFS_SLOT_OFFSET: return slot_offs_m;
			OFFS_SLOT_CTRL:   return {27'h0, target_dataslot_ack, target_dataslot_done,
			                          target_dataslot_err};
			OFFS_TICK_PERIOD: return tick_m;
			OFFS_IRQ_THRESH:  return thresh_m;
			OFFS_IRQ_MASK:    return {31'h0, mask_m};
			default:          return '0;
		endcase
	endfunction

	task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [OFFS_W-1:0] offs;
		offs = addr[OFFS_W-1:0];
		if (addr[ADDR_W-1:OFFS_W] == CPU_REG_BASE) begin
			if (offs < 8'h20 && offs[1:0] == 2'b00) mbox_model[offs[4:2]] = data;
			case (offs)
				OFFS_SLOT_ID:     slot_id_m   = data;
				OFFS_SLOT_ADDR:   slot_addr_m = data;
				OFFS_SLOT_LEN:    slot_len_m  = data;
				OFFS_SLOT_OFFSET: slot_offs_m = data;
				OFFS_TICK_PERIOD: tick_m      = data;
				OFFS_IRQ_THRESH:  thresh_m    = data;
				OFFS_IRQ_MASK:    mask_m      = data[0];
				default: ;
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
	                           input logic [DATA_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", test_name, name, exp, act);
		end
	endtask

	task automatic note_timeout(input string what);
		errors++;
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
	endtask

	// Compare every response with the model value captured at issue
	always @(negedge clk_sys) begin : compare_rsp
		logic [DATA_W-1:0] exp_v;
		bit chk_v;
		string name_v;
		if (reset_n && rsp_ready) begin
			if (pend_exp.size() == 0) begin
				errors++;
				$display("Response arrived with no command outstanding");
			end else begin
				exp_v  = pend_exp.pop_front();
				chk_v  = pend_chk.pop_front();
				name_v = pend_name.pop_front();
				if (chk_v) check_value(name_v, exp_v, rsp_data);
			end
		end
	end

	always @(negedge clk_sys) begin   // One count per high cycle
		if (target_dataslot_read) read_pulses++;
		if (target_dataslot_write) write_pulses++;
	end

	// Drives one command from a falling edge
	task automatic issue(input logic wr, input logic [ADDR_W-1:0] addr,
	                     input logic [DATA_W-1:0] data, input bit chk, input string name);
		cmd_valid   = 1'b1;
		cmd_wr      = wr;
		cmd_addr    = addr;
		cmd_wr_data = data;
		pend_exp.push_back(expected_read(addr));
		pend_chk.push_back(chk && !wr);   // Writes answer with no data
		pend_name.push_back(name);
		if (wr) model_write(addr, data);
	endtask

	task automatic cpu_access(input logic wr, input logic [ADDR_W-1:0] addr,
	                          input logic [DATA_W-1:0] data, input bit chk, input string name);
		int n;
		@(negedge clk_sys);
		issue(wr, addr, data, chk, name);
		@(negedge clk_sys);
		cmd_valid = 1'b0;
		n = 1;
		while (!rsp_ready && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rsp_ready) begin
			note_timeout({"response to ", name});
		end else begin
			check_value({name, " latency"}, 1, n);
		end
		last_rd = rsp_data;   // Left at the response edge
	endtask

	task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		cpu_access(1'b1, addr, data, 1'b0, "write");
	endtask

	task automatic cpu_read(input logic [ADDR_W-1:0] addr, input string name);
		cpu_access(1'b0, addr, '0, 1'b1, name);
	endtask

	task automatic drain(input string what);
		int n;
		n = 0;
		while (pend_exp.size() != 0 && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (pend_exp.size() != 0) note_timeout(what);
	endtask

	// Back-to-back reads of the whole mailbox
	task automatic read_burst(input string name);
		@(negedge clk_sys);
		for (int i = 0; i < MBOX_COUNT; i++) begin
			issue(1'b0, CPU_BASE + ADDR_W'(i * 4), '0, 1'b1, name);
			@(negedge clk_sys);
		end
		cmd_valid = 1'b0;
		drain(name);
	endtask

	task automatic host_write(input int idx, input logic [DATA_W-1:0] data);
		@(negedge clk_sys);
		bridge_wr      = 1'b1;
		bridge_addr    = HOST_BASE + ADDR_W'(idx * 4);
		bridge_wr_data = data;
		mbox_model[idx] = data;
		@(negedge clk_sys);
		bridge_wr = 1'b0;
	endtask

	task automatic host_read(input int idx, input string name);
		@(negedge clk_sys);
		bridge_rd   = 1'b1;
		bridge_addr = HOST_BASE + ADDR_W'(idx * 4);
		@(negedge clk_sys);
		bridge_rd = 1'b0;
		check_value({name, " hold"}, host_last, bridge_rd_data);   // Not yet the new word
		@(negedge clk_sys);   // Two cycles after bridge_rd
		check_value(name, mbox_model[idx], bridge_rd_data);
		host_last = mbox_model[idx];
	endtask

	// Host and CPU hit the same word in one cycle
	task automatic collide_write(input int idx, input logic [DATA_W-1:0] host_d,
	                             input logic [DATA_W-1:0] cpu_d);
		@(negedge clk_sys);
		issue(1'b1, CPU_BASE + ADDR_W'(idx * 4), cpu_d, 1'b0, "collide");
		bridge_wr      = 1'b1;
		bridge_addr    = HOST_BASE + ADDR_W'(idx * 4);
		bridge_wr_data = host_d;
		mbox_model[idx] = host_d;   // Host wins
		@(negedge clk_sys);
		cmd_valid = 1'b0;
		bridge_wr = 1'b0;
		drain("collision write response");
	endtask

	task automatic wait_irq(input bit timer, input string what);
		int n;
		n = 0;
		while (!(timer ? timer_irq : slot_irq) && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!(timer ? timer_irq : slot_irq)) note_timeout(what);
	endtask

	task automatic start_test(input string name);
		tests++;
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		$display("Test %-10s %s, %0d error(s)", test_name,
		         (errors == test_err0) ? "ok" : "failed", errors - test_err0);
	endtask

	initial begin : stimulus
		logic [DATA_W-1:0] rnd;
		logic [DATA_W-1:0] first;
		int rp;
		int wp;
		clk_sys = 1'b0;
		reset_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_wr = 1'b0;
		cmd_addr = '0;
		cmd_wr_data = '0;
		bridge_wr = 1'b0;
		bridge_rd = 1'b0;
		bridge_addr = '0;
		bridge_wr_data = '0;
		target_dataslot_ack = 1'b0;
		target_dataslot_done = 1'b0;
		target_dataslot_err = '0;
		for (int i = 0; i < MBOX_COUNT; i++) mbox_model[i] = '0;
		{slot_id_m, slot_addr_m, slot_len_m, slot_offs_m, tick_m, thresh_m} = '0;
		mask_m = 1'b0;
		host_last = '0;   // Reset value of the host read port
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1;

		start_test("mbox_cpu");
		for (int i = 0; i < MBOX_COUNT; i++) cpu_write(CPU_BASE + ADDR_W'(i * 4), $random(seed));
		for (int i = 0; i < MBOX_COUNT; i++) cpu_read(CPU_BASE + ADDR_W'(i * 4), "mbox read");
		read_burst("mbox burst");
		for (int i = 0; i < MBOX_COUNT; i++) host_read(i, "host read");
		end_test();

		start_test("mbox_host");
		for (int i = 0; i < MBOX_COUNT; i++) host_write(i, $random(seed));
		read_burst("host data burst");
		collide_write(3, $random(seed), $random(seed));
		cpu_read(CPU_BASE + 32'h0C, "collide readback");
		end_test();

		start_test("slot_cmd");
		cpu_write(CPU_BASE + OFFS_SLOT_ID, $random(seed));
		cpu_write(CPU_BASE + OFFS_SLOT_ADDR, $random(seed));
		cpu_write(CPU_BASE + OFFS_SLOT_LEN, $random(seed));
		cpu_write(CPU_BASE + OFFS_SLOT_OFFSET, $random(seed));
		cpu_read(CPU_BASE + OFFS_SLOT_ID, "slot id");
		cpu_read(CPU_BASE + OFFS_SLOT_ADDR, "slot addr");
		cpu_read(CPU_BASE + OFFS_SLOT_LEN, "slot len");
		cpu_read(CPU_BASE + OFFS_SLOT_OFFSET, "slot offset");
		check_value("id out", {16'h0, slot_id_m[15:0]}, DATA_W'(target_dataslot_id));
		check_value("addr out", slot_addr_m, target_dataslot_bridgeaddr);
		check_value("len out", slot_len_m, target_dataslot_length);
		check_value("offset out", slot_offs_m, target_dataslot_slotoffset);
		rp = read_pulses;
		wp = write_pulses;
		cpu_write(CPU_BASE + OFFS_SLOT_CTRL, 32'h1);
		check_value("read pulse timing", 1, DATA_W'(target_dataslot_read));
		cpu_write(CPU_BASE + OFFS_SLOT_CTRL, 32'h2);
		check_value("write pulse timing", 1, DATA_W'(target_dataslot_write));
		repeat (3) @(negedge clk_sys);   // Let any extra pulse show
		check_value("read pulse count", 1, read_pulses - rp);
		check_value("write pulse count", 1, write_pulses - wp);
		end_test();

		start_test("slot_irq");
		cpu_write(CPU_BASE + OFFS_SLOT_CTRL, 32'h4);   // Interrupt enable only
		@(negedge clk_sys);
		rnd = $random(seed);
		target_dataslot_ack  = 1'b1;
		target_dataslot_err  = rnd[2:0];
		target_dataslot_done = 1'b1;   // Rising done
		wait_irq(1'b0, "slot_irq after done");
		cpu_read(CPU_BASE + OFFS_SLOT_CTRL, "slot status");
		check_value("slot_irq cleared", 0, DATA_W'(slot_irq));
		target_dataslot_done = 1'b0;
		target_dataslot_ack  = 1'b0;
		cpu_write(CPU_BASE + OFFS_SLOT_CTRL, 32'h0);   // Enable off
		@(negedge clk_sys);
		target_dataslot_done = 1'b1;
		repeat (20) begin
			@(negedge clk_sys);
			check_value("slot_irq disabled", 0, DATA_W'(slot_irq));
		end
		target_dataslot_done = 1'b0;
		end_test();

		start_test("timer");
		cpu_write(CPU_BASE + OFFS_TICK_PERIOD, 32'd9);
		cpu_write(CPU_BASE + OFFS_MS_COUNT, 32'h1);   // Clear count and tick
		cpu_write(CPU_BASE + OFFS_IRQ_THRESH, 32'd3);
		cpu_write(CPU_BASE + OFFS_IRQ_MASK, 32'h1);
		cpu_read(CPU_BASE + OFFS_TICK_PERIOD, "tick period");
		cpu_read(CPU_BASE + OFFS_IRQ_THRESH, "threshold");
		cpu_read(CPU_BASE + OFFS_IRQ_MASK, "mask");
		wait_irq(1'b1, "timer_irq");
		cpu_access(1'b0, CPU_BASE + OFFS_MS_COUNT, '0, 1'b0, "count");
		first = last_rd;
		check_value("count at least 3", 1, DATA_W'(first >= 32'd3));
		cpu_access(1'b0, CPU_BASE + OFFS_MS_COUNT, '0, 1'b0, "count again");
		check_value("count not decreasing", 1, DATA_W'(last_rd >= first));
		cpu_write(CPU_BASE + OFFS_MS_COUNT, 32'h1);
		check_value("timer_irq cleared", 0, DATA_W'(timer_irq));
		end_test();

		start_test("unmapped");
		cpu_read(32'h0000_0010, "outside region");
		cpu_read(CPU_BASE + 32'h40, "unmapped offset");
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mcu_periph.f */
src/mcu_periph_pkg.sv
src/cpu_bus_decoder.sv
src/mailbox_regs.sv
src/ms_timer.sv
src/dataslot_cmd.sv
src/mcu_periph_top.sv
sim/mcu_periph_properties.sv
sim/tb_mcu_periph.sv

/* Makefile */
VERILATOR   := verilator
TOP         := tb_mcu_periph
FILELIST    := mcu_periph.f
BUILD_FLAGS := --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS  := --lint-only --timing --assert --top-module $(TOP)
OBJ_DIR     := obj_dir
LOG         := sim.log
PASS_MSG    := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
